// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_udp_loop
FILELIST  ?= list.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: list.f
source/udp_pkg.sv
source/credit_fifo.sv
source/pkt_gen.sv
source/width_down.sv
source/width_up.sv
source/pkt_check.sv
source/udp_loop_top.sv
sim/tb_udp_loop.sv

// File: sim/tb_udp_loop.sv
`timescale 1ns/100ps

module tb_udp_loop;
  import udp_pkg::*;

  typedef struct packed {
    logic [BURST_W-1:0] len;
    int                 corrupt;                       // narrow beat index in burst or -1
    int                 max_delay;                     // tx credit return delay
    logic [BURST_W-1:0] exp_pkts;
    logic [ERR_W-1:0]   exp_errs;
    logic               exp_flag;
  } row_t;

  localparam int N_ROWS = 5;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               burst_start;
  logic [BURST_W-1:0] burst_len;
  logic               busy;
  logic               tx_valid;
  narrow_beat_t       tx_beat;
  logic               tx_credit;
  logic               rx_valid;
  narrow_beat_t       rx_beat;
  logic               rx_credit;
  logic [BURST_W-1:0] pkt_count;
  logic [ERR_W-1:0]   err_count;
  logic               err_flag;

  row_t         rows [N_ROWS];
  int           limit;
  int           cycles = 0;
  int           row_errs = 0;
  int           pass_n = 0;
  int           fail_n = 0;
  int           cur_delay = 0;
  int           cur_corrupt = -1;
  int           row_tx = 0;
  narrow_beat_t last_tx;
  narrow_beat_t loop_q [$];                            // beats on their way back to rx
  int           due_q [$];                             // cycle each tx credit goes back
  int           link_cycle = 0;
  int           rx_credits = 0;
  int           outstanding = 0;
  int           tx_pkt = 0;
  int           tx_n = 0;

  udp_loop_top UUT (
    .clk(clk), .rst_n(rst_n), .burst_start(burst_start), .burst_len(burst_len),
    .busy(busy), .tx_valid(tx_valid), .tx_beat(tx_beat), .tx_credit(tx_credit),
    .rx_valid(rx_valid), .rx_beat(rx_beat), .rx_credit(rx_credit),
    .pkt_count(pkt_count), .err_count(err_count), .err_flag(err_flag)
  );

  always #50 clk = ~clk;

  // narrow beat n (0..4) of packet pkt from the word numbering
  function automatic narrow_beat_t expect_narrow(input int pkt, input int n);
    narrow_beat_t e;
    e = '0;
    for (int w = 0; w < NARROW_W / WORD_W; w++) begin
      e.data[w * WORD_W +: WORD_W] = pkt * 256 + (n / 2) * 16 + (n % 2) * 8 + w;
    end
    e.keep = '1;                                       // only the dropped upper half is empty
    e.last = (n == 4);
    return e;
  endfunction

  task automatic check(input string what, input logic [WIDE_W-1:0] got,
                       input logic [WIDE_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      row_errs++;
    end
  endtask

  task automatic report(input string name);
    if (row_errs == 0) begin
      pass_n++;
      $display("%s: ok", name);
    end else begin
      fail_n++;
      $display("%s: %0d mismatches", name, row_errs);
    end
    row_errs = 0;
  endtask

  // far end of both links
  always @(posedge clk) begin : link_model
    narrow_beat_t looped;
    if (!rst_n) begin
      rx_credits = FIFO_DEPTH;
      outstanding = 0;
      tx_credit <= 1'b0;
      rx_valid  <= 1'b0;
    end else begin
      link_cycle++;
      if (rx_credit) rx_credits++;
      if (tx_valid) begin
        check("tx beat", tx_beat, expect_narrow(tx_pkt, tx_n));
        looped = tx_beat;
        if (row_tx == cur_corrupt) looped.data[5] = ~looped.data[5];   // injected fault
        loop_q.push_back(looped);
        due_q.push_back(link_cycle + int'($urandom % (cur_delay + 1)));
        last_tx = tx_beat;
        row_tx++;
        outstanding++;
        check("tx beats outstanding within credits", outstanding <= LINK_CREDITS, 1'b1);
        tx_pkt = (tx_n == 4) ? tx_pkt + 1 : tx_pkt;
        tx_n   = (tx_n == 4) ? 0 : tx_n + 1;
      end
      tx_credit <= 1'b0;
      if (due_q.size() > 0 && due_q[0] <= link_cycle) begin
        tx_credit <= 1'b1;
        void'(due_q.pop_front());
        outstanding--;
      end
      rx_valid <= 1'b0;
      if (loop_q.size() > 0 && rx_credits > 0) begin
        rx_valid <= 1'b1;
        rx_beat  <= loop_q.pop_front();
        rx_credits--;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: no result after %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int                 seed;
    int                 pkt_seen;
    logic [BURST_W-1:0] pkt_prev;
    rst_n = 1'b0;
    burst_start = 1'b0;
    burst_len = '0;
    tx_credit = 1'b0;
    rx_valid = 1'b0;
    rx_beat = '0;
    seed = 11;
    void'($urandom(seed));
    //         len    corrupt delay pkts    errs     flag
    rows[0] = '{8'd1, -1,     0,    8'd1,   16'd0,   1'b0};
    rows[1] = '{8'd6, -1,     8,    8'd7,   16'd0,   1'b0};
    rows[2] = '{8'd2, 3,      2,    8'd9,   16'd1,   1'b1};
    rows[3] = '{8'd3, -1,     1,    8'd12,  16'd1,   1'b1};  // sequence carries on
    rows[4] = '{8'd4, -1,     12,   8'd16,  16'd1,   1'b1};  // credits held back long
    limit = 500;
    foreach (rows[i]) limit += int'(rows[i].len) * 5 * (rows[i].max_delay + 4);
    repeat (16) @(posedge clk);
    check("tx_valid", tx_valid, 1'b0);
    check("rx_credit", rx_credit, 1'b0);
    check("busy", busy, 1'b0);
    check("counters", {pkt_count, err_count, err_flag}, '0);
    report("reset state");
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int i = 0; i < N_ROWS; i++) begin
      cur_delay   = rows[i].max_delay;
      cur_corrupt = rows[i].corrupt;
      row_tx      = 0;
      pkt_prev    = pkt_count;
      pkt_seen    = 0;
      burst_start <= 1'b1;
      burst_len   <= rows[i].len;
      @(posedge clk);
      burst_start <= 1'b0;
      // every pkt_count step marks one packet at the checker
      while (busy || pkt_seen < int'(rows[i].len)) begin
        @(posedge clk);
        if (pkt_count != pkt_prev) pkt_seen++;
        pkt_prev = pkt_count;
      end
      check("pkt_count", pkt_count, rows[i].exp_pkts);
      check("err_count", err_count, rows[i].exp_errs);
      check("err_flag", err_flag, rows[i].exp_flag);
      check("tx beats in burst", row_tx, int'(rows[i].len) * 5);
      check("final tx keep and last", {last_tx.keep, last_tx.last}, {32'hffff_ffff, 1'b1});
      report($sformatf("row %0d (burst %0d, delay %0d, corrupt %0d)", i, rows[i].len,
                       rows[i].max_delay, rows[i].corrupt));
    end
    $display("%0d tests passed, %0d tests failed", pass_n, fail_n);
    if (fail_n == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: source/credit_fifo.sv
`timescale 1ns/100ps

module credit_fifo #(
  parameter type payload_t   = udp_pkg::narrow_beat_t,
  parameter int  FIFO_DEPTH  = udp_pkg::FIFO_DEPTH,
  parameter int  OUT_CREDITS = udp_pkg::LINK_CREDITS
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_item,
  output logic     in_credit,
  output logic     out_valid,
  output payload_t out_item,
  input  logic     out_credit
);
  import udp_pkg::*;

  payload_t                        mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] fill;
  logic [CREDIT_W-1:0]             credits;           // slots free downstream
  logic                            pop;

  assign pop = (fill != '0) && (credits != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      credits   <= CREDIT_W'(OUT_CREDITS);
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      out_valid <= pop;
      in_credit <= pop;                                 // slot freed on every pop
      credits   <= credits - CREDIT_W'(pop) + CREDIT_W'(out_credit);
      fill      <= fill + in_valid - pop;
      if (in_valid) begin
        wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_item;
    end
    if (pop) begin
      out_item <= mem[rd_ptr];
    end
  end

endmodule

// File: source/pkt_check.sv
`timescale 1ns/100ps

module pkt_check (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  udp_pkg::wide_beat_t         in_item,
  output logic                        in_credit,
  output logic [udp_pkg::BURST_W-1:0] pkt_count,
  output logic [udp_pkg::ERR_W-1:0]   err_count,
  output logic                        err_flag
);
  import udp_pkg::*;

  logic [PKT_SEQ_W-1:0] pkt_seq;
  logic [BEAT_W-1:0]    beat;
  wide_beat_t           expected;
  logic                 mismatch;

  assign expected = pattern_beat(pkt_seq, beat);
  assign mismatch = (in_item != expected);            // data, keep or last

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_credit <= 1'b0;
      pkt_seq   <= '0;
      beat      <= '0;
      pkt_count <= '0;
      err_count <= '0;
      err_flag  <= 1'b0;
    end else begin
      in_credit <= in_valid;                            // always sinks, credit next cycle
      if (in_valid) begin
        if (beat == BEAT_W'(PKT_WIDE_BEATS - 1)) begin
          beat    <= '0;
          pkt_seq <= pkt_seq + 1'b1;
        end else begin
          beat <= beat + 1'b1;
        end
        if (mismatch) begin
          err_count <= err_count + 1'b1;
          err_flag  <= 1'b1;                            // sticky
        end
        if (in_item.last) begin
          pkt_count <= pkt_count + 1'b1;
        end
      end
    end
  end

endmodule

// File: source/pkt_gen.sv
`timescale 1ns/100ps

module pkt_gen (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        burst_start,
  input  logic [udp_pkg::BURST_W-1:0] burst_len,
  output logic                        busy,
  output logic                        out_valid,
  output udp_pkg::wide_beat_t         out_item,
  input  logic                        out_credit
);
  import udp_pkg::*;

  logic [CREDIT_W-1:0]  credits;
  logic [BURST_W-1:0]   pkts_left;
  logic [PKT_SEQ_W-1:0] pkt_seq;                       // runs on across bursts
  logic [BEAT_W-1:0]    beat;
  logic                 send;

  assign send = busy && (credits != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      out_valid <= 1'b0;
      credits   <= CREDIT_W'(FIFO_DEPTH);
      pkts_left <= '0;
      pkt_seq   <= '0;
      beat      <= '0;
    end else begin
      out_valid <= send;
      credits   <= credits - CREDIT_W'(send) + CREDIT_W'(out_credit);
      if (!busy && burst_start && (burst_len != '0)) begin
        busy      <= 1'b1;
        pkts_left <= burst_len;
      end
      if (send) begin
        if (beat == BEAT_W'(PKT_WIDE_BEATS - 1)) begin  // packet done
          beat      <= '0;
          pkt_seq   <= pkt_seq + 1'b1;
          pkts_left <= pkts_left - 1'b1;
          if (pkts_left == BURST_W'(1)) begin
            busy <= 1'b0;
          end
        end else begin
          beat <= beat + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      out_item <= pattern_beat(pkt_seq, beat);
    end
  end

endmodule

// File: source/udp_loop_top.sv
`timescale 1ns/100ps

module udp_loop_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        burst_start,
  input  logic [udp_pkg::BURST_W-1:0] burst_len,
  output logic                        busy,
  output logic                        tx_valid,
  output udp_pkg::narrow_beat_t       tx_beat,
  input  logic                        tx_credit,
  input  logic                        rx_valid,
  input  udp_pkg::narrow_beat_t       rx_beat,
  output logic                        rx_credit,
  output logic [udp_pkg::BURST_W-1:0] pkt_count,
  output logic [udp_pkg::ERR_W-1:0]   err_count,
  output logic                        err_flag
);
  import udp_pkg::*;

  logic         gen_valid,  gen_credit;
  wide_beat_t   gen_beat;
  logic         dn_valid,   dn_credit;
  wide_beat_t   dn_beat;                               // gen_fifo to width_down
  logic         nar_valid,  nar_credit;
  narrow_beat_t nar_beat;                              // width_down to tx_fifo
  logic         up_valid,   up_credit;
  narrow_beat_t up_beat;                               // rx_fifo to width_up
  logic         chk_valid,  chk_credit;
  wide_beat_t   chk_beat;

  pkt_gen u_pkt_gen (
    .clk(clk), .rst_n(rst_n), .burst_start(burst_start), .burst_len(burst_len),
    .busy(busy), .out_valid(gen_valid), .out_item(gen_beat), .out_credit(gen_credit)
  );

  credit_fifo #(.payload_t(wide_beat_t), .OUT_CREDITS(CONV_SLOTS)) gen_fifo (
    .clk(clk), .rst_n(rst_n), .in_valid(gen_valid), .in_item(gen_beat),
    .in_credit(gen_credit), .out_valid(dn_valid), .out_item(dn_beat), .out_credit(dn_credit)
  );

  width_down u_width_down (
    .clk(clk), .rst_n(rst_n), .in_valid(dn_valid), .in_item(dn_beat), .in_credit(dn_credit),
    .out_valid(nar_valid), .out_item(nar_beat), .out_credit(nar_credit)
  );

  credit_fifo #(.payload_t(narrow_beat_t), .OUT_CREDITS(LINK_CREDITS)) tx_fifo (
    .clk(clk), .rst_n(rst_n), .in_valid(nar_valid), .in_item(nar_beat),
    .in_credit(nar_credit), .out_valid(tx_valid), .out_item(tx_beat), .out_credit(tx_credit)
  );

  credit_fifo #(.payload_t(narrow_beat_t), .OUT_CREDITS(CONV_SLOTS)) rx_fifo (
    .clk(clk), .rst_n(rst_n), .in_valid(rx_valid), .in_item(rx_beat),
    .in_credit(rx_credit), .out_valid(up_valid), .out_item(up_beat), .out_credit(up_credit)
  );

  width_up u_width_up (
    .clk(clk), .rst_n(rst_n), .in_valid(up_valid), .in_item(up_beat), .in_credit(up_credit),
    .out_valid(chk_valid), .out_item(chk_beat), .out_credit(chk_credit)
  );

  pkt_check u_pkt_check (
    .clk(clk), .rst_n(rst_n), .in_valid(chk_valid), .in_item(chk_beat),
    .in_credit(chk_credit), .pkt_count(pkt_count), .err_count(err_count), .err_flag(err_flag)
  );

endmodule

// File: source/udp_pkg.sv
package udp_pkg;

  localparam int WIDE_W         = 512;
  localparam int NARROW_W       = 256;
  localparam int WIDE_KEEP_W    = WIDE_W / 8;
  localparam int NARROW_KEEP_W  = NARROW_W / 8;
  localparam int PKT_BYTES      = 160;                 // 2.5 wide beats
  localparam int PKT_WIDE_BEATS = 3;
  localparam int FIFO_DEPTH     = 4;
  localparam int LINK_CREDITS   = 4;                   // granted by the far end
  localparam int CONV_SLOTS     = 1;                   // width converters hold one item
  localparam int CHECK_SLOTS    = 1;
  localparam int CREDIT_W       = 3;
  localparam int BURST_W        = 8;
  localparam int ERR_W          = 16;
  localparam int BEAT_W         = 2;
  localparam int PKT_SEQ_W      = 24;                  // sequence wraps at 2^24
  localparam int WORD_W         = 32;

  typedef struct packed {
    logic [WIDE_W-1:0]      data;
    logic [WIDE_KEEP_W-1:0] keep;
    logic                   last;
  } wide_beat_t;

  typedef struct packed {
    logic [NARROW_W-1:0]      data;
    logic [NARROW_KEEP_W-1:0] keep;
    logic                     last;
  } narrow_beat_t;

  // test pattern shared by generator and checker
  function automatic wide_beat_t pattern_beat(input logic [PKT_SEQ_W-1:0] pkt,
                                              input logic [BEAT_W-1:0]    beat);
    wide_beat_t b;
    int         nbytes;
    b      = '0;
    nbytes = PKT_BYTES - int'(beat) * WIDE_KEEP_W;     // bytes left from this beat on
    for (int i = 0; i < WIDE_KEEP_W; i++) begin
      b.keep[i] = (i < nbytes);
    end
    for (int w = 0; w < WIDE_W / WORD_W; w++) begin
      if (b.keep[w * WORD_W / 8]) begin
        b.data[w * WORD_W +: WORD_W] = {pkt, 8'h00} + WORD_W'(beat) * 16 + WORD_W'(w);
      end
    end
    b.last = (beat == BEAT_W'(PKT_WIDE_BEATS - 1));
    return b;
  endfunction

endpackage

// File: source/width_down.sv
`timescale 1ns/100ps

module width_down (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  udp_pkg::wide_beat_t   in_item,
  output logic                  in_credit,
  output logic                  out_valid,
  output udp_pkg::narrow_beat_t out_item,
  input  logic                  out_credit
);
  import udp_pkg::*;

  wide_beat_t          hold;
  logic                full;
  logic                upper;                          // next half to send is the top one
  logic                skip_upper;
  logic                send;
  logic [CREDIT_W-1:0] credits;

  assign send       = full && (credits != '0);
  assign skip_upper = (hold.keep[WIDE_KEEP_W-1:NARROW_KEEP_W] == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full      <= 1'b0;
      upper     <= 1'b0;
      credits   <= CREDIT_W'(FIFO_DEPTH);
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      out_valid <= send;
      in_credit <= 1'b0;
      credits   <= credits - CREDIT_W'(send) + CREDIT_W'(out_credit);
      if (send) begin
        if (upper || skip_upper) begin
          full      <= 1'b0;
          upper     <= 1'b0;
          in_credit <= 1'b1;                            // last half gone, slot free
        end else begin
          upper <= 1'b1;
        end
      end
      if (in_valid) begin
        full  <= 1'b1;
        upper <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      hold <= in_item;
    end
    if (send) begin
      if (upper) begin
        out_item <= '{data: hold.data[WIDE_W-1:NARROW_W],
                      keep: hold.keep[WIDE_KEEP_W-1:NARROW_KEEP_W],
                      last: hold.last};
      end else begin
        out_item <= '{data: hold.data[NARROW_W-1:0],
                      keep: hold.keep[NARROW_KEEP_W-1:0],
                      last: hold.last && skip_upper};  // short tail ends on lower half
      end
    end
  end

endmodule

// File: source/width_up.sv
`timescale 1ns/100ps

module width_up (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  udp_pkg::narrow_beat_t in_item,
  output logic                  in_credit,
  output logic                  out_valid,
  output udp_pkg::wide_beat_t   out_item,
  input  logic                  out_credit
);
  import udp_pkg::*;

  narrow_beat_t        lo;
  wide_beat_t          wide_q;
  logic                have_lo;
  logic                pend;                           // wide beat waiting for a credit
  logic                send;
  logic [CREDIT_W-1:0] credits;

  assign send = pend && (credits != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      have_lo   <= 1'b0;
      pend      <= 1'b0;
      credits   <= CREDIT_W'(CHECK_SLOTS);
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      out_valid <= send;
      credits   <= credits - CREDIT_W'(send) + CREDIT_W'(out_credit);
      in_credit <= send || (in_valid && !have_lo && !in_item.last);
      if (send) begin
        pend <= 1'b0;
      end
      if (in_valid) begin
        if (have_lo) begin
          have_lo <= 1'b0;
          pend    <= 1'b1;
        end else if (in_item.last) begin
          pend <= 1'b1;                                 // tail fits in lower half
        end else begin
          have_lo <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && !have_lo) begin
      lo <= in_item;
    end
    if (in_valid && have_lo) begin
      wide_q <= '{data: {in_item.data, lo.data},
                  keep: {in_item.keep, lo.keep},
                  last: in_item.last};
    end else if (in_valid && in_item.last) begin
      wide_q <= '{data: {{NARROW_W{1'b0}}, in_item.data},
                  keep: {{NARROW_KEEP_W{1'b0}}, in_item.keep},
                  last: 1'b1};
    end
    if (send) begin
      out_item <= wide_q;
    end
  end

endmodule
